// File: logic/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // serial frame: start, 8 data, parity, stop
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = DATA_BITS + 3;

  // command word from local logic, wr is the msb
  typedef struct packed {
    logic       wr;    // 1 write, 0 read
    logic [6:0] addr;
    logic [7:0] data;  // don't care on reads
  } cmd_t;

  // one received response frame
  typedef struct packed {
    logic [7:0] data;
    logic       parity_ok;  // ones over data+parity are odd
    logic       stop_ok;    // stop bit sampled high
  } rx_result_t;

  typedef enum logic [2:0] {
    idle,
    send_addr,
    gap,
    send_data,
    wait_rsp,
    report
  } seq_state_e;

  // parity bit that makes the total count of ones odd
  function automatic logic odd_parity(input logic [7:0] b);
    return ~^b;
  endfunction

endpackage

// File: logic/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_done
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int IDX_W = $clog2(uart_cmd_pkg::FRAME_BITS);
  localparam int SHW   = uart_cmd_pkg::FRAME_BITS - 1;

  logic             busy;
  logic [CNT_W-1:0] clk_cnt;
  logic [IDX_W-1:0] bit_idx;   // 0 = start bit, FRAME_BITS-1 = stop bit
  logic [SHW-1:0]   frame_q;   // bits still to go out, lsb next
  logic             bit_end;
  logic             last_bit;

  assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign last_bit = (bit_idx == IDX_W'(uart_cmd_pkg::FRAME_BITS - 1));

  // high in the final cycle of the stop bit
  assign tx_done = busy && bit_end && last_bit;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (!busy)
    begin
      if (tx_start)
      begin
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_idx <= '0;
        tx      <= 1'b0;  // start bit
      end
    end
    else if (bit_end)
    begin
      clk_cnt <= '0;
      if (last_bit)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;  // back to idle level
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= frame_q[0];
      end
    end
    else
    begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // byte and parity latched at start, then shifted out lsb first
  always_ff @(posedge clk)
  begin
    if (!busy && tx_start)
      frame_q <= {1'b1, uart_cmd_pkg::odd_parity(tx_byte), tx_byte};
    else if (busy && bit_end)
      frame_q <= {1'b1, frame_q[SHW-1:1]};
  end

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  input  logic                    rx_arm,
  output logic                    rx_busy,
  output logic                    rx_valid,
  output uart_cmd_pkg::rx_result_t rx_result
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int HALF  = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;
  localparam int BIT_W = $clog2(uart_cmd_pkg::DATA_BITS);

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_e;

  rx_state_e        state;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic [CNT_W-1:0] clk_cnt;
  logic [BIT_W-1:0] bit_idx;
  logic [7:0]       shift_q;
  logic             par_ok;
  logic             fall;
  logic             bit_end;
  logic             half_end;

  // two-flop synchronizer plus one more stage for edge detect
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall     = rx_prev & ~rx_sync;
  assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign half_end = (clk_cnt == CNT_W'(HALF - 1));
  assign rx_busy  = (state != rx_idle);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= rx_idle;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        rx_idle:
        begin
          clk_cnt <= '0;
          if (rx_arm && fall)
            state <= rx_start;
        end
        rx_start:
        begin
          if (half_end)
          begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? rx_idle : rx_data;  // high here means a glitch
          end
        end
        rx_data:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == BIT_W'(uart_cmd_pkg::DATA_BITS - 1))
              state <= rx_parity;
          end
        end
        rx_parity:
        begin
          if (bit_end)
          begin
            clk_cnt <= '0;
            state   <= rx_stop;
          end
        end
        rx_stop:
        begin
          if (bit_end)
          begin
            state    <= rx_idle;
            rx_valid <= 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // data path, sampled at bit middles
  always_ff @(posedge clk)
  begin
    if (state == rx_data && bit_end)
      shift_q <= {rx_sync, shift_q[7:1]};  // lsb arrives first
    if (state == rx_parity && bit_end)
      par_ok <= ^{rx_sync, shift_q};
    if (state == rx_stop && bit_end)
    begin
      rx_result.data      <= shift_q;
      rx_result.parity_ok <= par_ok;
      rx_result.stop_ok   <= rx_sync;
    end
  end

endmodule

// File: logic/cmd_sequencer.sv
`timescale 1ns/1ns

module cmd_sequencer #(
  parameter int GAP_CYCLES       = 100,
  parameter int RSP_TIMEOUT_BITS = 32,
  parameter int CLKS_PER_BIT     = 434
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_cmd_pkg::cmd_t       cmd_in,
  input  logic                     cmd_vld,
  output logic                     cmd_rdy,
  output logic                     tx_start,
  output logic [7:0]               tx_byte,
  input  logic                     tx_done,
  output logic                     rx_arm,
  input  logic                     rx_busy,
  input  logic                     rx_valid,
  input  uart_cmd_pkg::rx_result_t rx_result,
  output logic [7:0]               read_data,
  output logic                     read_rdy,
  output logic                     rsp_err
);

  localparam int TIMEOUT_CYCLES = RSP_TIMEOUT_BITS * CLKS_PER_BIT;
  localparam int CNT_MAX = (GAP_CYCLES > TIMEOUT_CYCLES) ? GAP_CYCLES : TIMEOUT_CYCLES;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  uart_cmd_pkg::seq_state_e state;
  uart_cmd_pkg::cmd_t       cmd_q;
  logic [CNT_W-1:0]         cnt;      // shared by gap and response timeout
  logic                     rsp_ok;
  logic                     rsp_good;
  logic                     gap_end;
  logic                     rsp_timeout;

  assign gap_end     = (cnt == CNT_W'(GAP_CYCLES - 1));
  assign rsp_timeout = (cnt == CNT_W'(TIMEOUT_CYCLES - 1));
  assign rsp_good    = rx_result.parity_ok && rx_result.stop_ok;

  assign cmd_rdy  = (state == uart_cmd_pkg::idle);
  assign rx_arm   = (state == uart_cmd_pkg::wait_rsp);
  assign read_rdy = (state == uart_cmd_pkg::report) && rsp_ok;
  assign rsp_err  = (state == uart_cmd_pkg::report) && !rsp_ok;

  // first frame is {wr, addr}, second is the data byte
  assign tx_byte = (state == uart_cmd_pkg::send_data) ? cmd_q.data
                                                      : {cmd_q.wr, cmd_q.addr};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_cmd_pkg::idle;
      tx_start <= 1'b0;
      cnt      <= '0;
      rsp_ok   <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        uart_cmd_pkg::idle:
        begin
          if (cmd_vld)
          begin
            state    <= uart_cmd_pkg::send_addr;
            tx_start <= 1'b1;
          end
        end
        uart_cmd_pkg::send_addr:
        begin
          cnt <= '0;
          if (tx_done)
            state <= uart_cmd_pkg::gap;
        end
        uart_cmd_pkg::gap:
        begin
          if (gap_end)
          begin
            state    <= uart_cmd_pkg::send_data;
            tx_start <= 1'b1;
          end
          else
            cnt <= cnt + 1'b1;
        end
        uart_cmd_pkg::send_data:
        begin
          cnt <= '0;
          if (tx_done)
            state <= cmd_q.wr ? uart_cmd_pkg::idle : uart_cmd_pkg::wait_rsp;
        end
        uart_cmd_pkg::wait_rsp:
        begin
          if (rx_valid)
          begin
            state  <= uart_cmd_pkg::report;
            rsp_ok <= rsp_good;
          end
          else if (!rx_busy)  // timer frozen while a frame is coming in
          begin
            if (rsp_timeout)
            begin
              state  <= uart_cmd_pkg::report;
              rsp_ok <= 1'b0;
            end
            else
              cnt <= cnt + 1'b1;
          end
        end
        uart_cmd_pkg::report: state <= uart_cmd_pkg::idle;
        default:              state <= uart_cmd_pkg::idle;
      endcase
    end
  end

  // command capture and read result
  always_ff @(posedge clk)
  begin
    if (state == uart_cmd_pkg::idle && cmd_vld)
      cmd_q <= cmd_in;
    if (state == uart_cmd_pkg::wait_rsp && rx_valid && rsp_good)
      read_data <= rx_result.data;  // kept until the next good response
  end

endmodule

// File: logic/uart_cmd_master.sv
`timescale 1ns/1ns

module uart_cmd_master #(
  parameter int CLKS_PER_BIT     = 434,
  parameter int GAP_CYCLES       = 100,
  parameter int RSP_TIMEOUT_BITS = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_cmd_pkg::cmd_t cmd_in,
  input  logic               cmd_vld,
  input  logic               rx,
  output logic               tx,
  output logic               cmd_rdy,
  output logic [7:0]         read_data,
  output logic               read_rdy,
  output logic               rsp_err
);

  logic                     tx_start;
  logic [7:0]               tx_byte;
  logic                     tx_done;
  logic                     rx_arm;
  logic                     rx_busy;
  logic                     rx_valid;
  uart_cmd_pkg::rx_result_t rx_result;

  cmd_sequencer #(
    .GAP_CYCLES       (GAP_CYCLES),
    .RSP_TIMEOUT_BITS (RSP_TIMEOUT_BITS),
    .CLKS_PER_BIT     (CLKS_PER_BIT)
  ) i_cmd_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_arm    (rx_arm),
    .rx_busy   (rx_busy),
    .rx_valid  (rx_valid),
    .rx_result (rx_result),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .rsp_err   (rsp_err)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  // response path, only listens while the sequencer arms it
  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_arm    (rx_arm),
    .rx_busy   (rx_busy),
    .rx_valid  (rx_valid),
    .rx_result (rx_result)
  );

endmodule

// File: verification/tb_serial_model.svh
`ifndef TB_SERIAL_MODEL_SVH
`define TB_SERIAL_MODEL_SVH

// remote device side of the link, sampled on the falling clock edge
task automatic capture_frame(output logic [7:0] b, output logic st, output logic par,
                             output logic stp);
  int i;
  @(negedge tx);
  repeat (CPB / 2) @(negedge clk);
  st = tx;  // middle of start bit
  for (i = 0; i < 8; i++)
  begin
    repeat (CPB) @(negedge clk);
    b[i] = tx;  // lsb first
  end
  repeat (CPB) @(negedge clk);
  par = tx;
  repeat (CPB) @(negedge clk);
  stp = tx;
  last_stop_cycle = cycle_cnt;
endtask

// response frame on rx, parity bit chosen by the caller
task automatic send_frame(input logic [7:0] b, input logic par);
  logic [10:0] bits;
  int          i;
  bits = {1'b1, par, b, 1'b0};
  for (i = 0; i < 11; i++)
  begin
    rx <= bits[i];
    repeat (CPB) @(posedge clk);
  end
endtask

// both command frames, with framing checks on each
task automatic capture_cmd(output uart_cmd_pkg::cmd_t got);
  logic [7:0] b0;
  logic [7:0] b1;
  logic       st;
  logic       par;
  logic       stp;
  capture_frame(b0, st, par, stp);
  check_flag("tx start bit", 1'b0, st);
  check_flag("tx parity", uart_cmd_pkg::odd_parity(b0), par);
  check_flag("tx stop bit", 1'b1, stp);
  capture_frame(b1, st, par, stp);
  check_flag("tx start bit", 1'b0, st);
  check_flag("tx parity", uart_cmd_pkg::odd_parity(b1), par);
  check_flag("tx stop bit", 1'b1, stp);
  got = {b0, b1};
endtask

`endif

// File: verification/tb_uart_cmd_master.sv
`timescale 1ns/1ns

module tb_uart_cmd_master;

  localparam int CPB    = 8;
  localparam int GAP    = 20;
  localparam int TOB    = 16;
  localparam int FRAMES = 29;  // frames over all tests
  localparam int CMDS   = 12;
  localparam int LIMIT  = 2 * (FRAMES * 11 * CPB + CMDS * GAP + TOB * CPB + 10);
  localparam int RDY_LIMIT = 4 * (11 * CPB + GAP + TOB * CPB);

  logic               clk;
  logic               rst_n;
  uart_cmd_pkg::cmd_t cmd_in;
  logic               cmd_vld;
  logic               rx;
  logic               tx;
  logic               cmd_rdy;
  logic [7:0]         read_data;
  logic               read_rdy;
  logic               rsp_err;

  int          cycle_cnt = 0;
  int          pass_cnt = 0;
  int          err_cnt = 0;
  int          rdy_pulses = 0;
  int          err_pulses = 0;
  int          err_cycle = 0;
  int          last_stop_cycle = 0;
  int          seed = 32'h6a2f826c;
  logic [7:0]  mem [128];  // what the remote device holds

  task automatic check_cmd(input string name, input uart_cmd_pkg::cmd_t exp,
                           input uart_cmd_pkg::cmd_t got);
    if (got !== exp)
    begin
      $display("Error: %s expected %h got %h", name, exp, got);
      err_cnt++;
    end
    else
      pass_cnt++;
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp)
    begin
      $display("Error: %s expected %h got %h", name, exp, got);
      err_cnt++;
    end
    else
      pass_cnt++;
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp)
    begin
      $display("Error: %s expected %h got %h", name, exp, got);
      err_cnt++;
    end
    else
      pass_cnt++;
  endtask

  `include "tb_serial_model.svh"

  uart_cmd_master #(
    .CLKS_PER_BIT     (CPB),
    .GAP_CYCLES       (GAP),
    .RSP_TIMEOUT_BITS (TOB)
  ) i_uart_cmd_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .rsp_err   (rsp_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT)
    begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  always @(negedge clk)
  begin
    if (read_rdy)
      rdy_pulses++;
    if (rsp_err)
    begin
      err_pulses++;
      err_cycle = cycle_cnt;
    end
  end

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rdy && n < RDY_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy)
    begin
      $display("cmd_rdy did not come back high after the command");
      err_cnt++;
    end
  endtask

  task automatic send_cmd(input uart_cmd_pkg::cmd_t c);
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  // mode 0 no response, 1 good response, 2 response with flipped parity
  task automatic do_cmd(input uart_cmd_pkg::cmd_t c, input int mode, input logic [7:0] rsp);
    uart_cmd_pkg::cmd_t got;
    logic               par;
    send_cmd(c);
    capture_cmd(got);
    check_cmd("tx frames", c, got);
    if (mode != 0)
    begin
      repeat (2 * CPB) @(posedge clk);
      par = uart_cmd_pkg::odd_parity(rsp);
      send_frame(rsp, (mode == 2) ? ~par : par);
    end
    wait_idle();
  endtask

  function automatic uart_cmd_pkg::cmd_t rand_cmd(input logic wr);
    logic [31:0]        r;
    uart_cmd_pkg::cmd_t c;
    r = $random(seed);
    c.wr   = wr;
    c.addr = r[6:0];
    c.data = r[15:8];
    return c;
  endfunction

  task automatic test_done(input string name, input int errs_before);
    $display("%s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic test_reset();
    int e0;
    e0 = err_cnt;
    repeat (4) @(negedge clk);
    check_flag("tx", 1'b1, tx);
    check_flag("cmd_rdy", 1'b1, cmd_rdy);
    check_flag("read_rdy", 1'b0, read_rdy);
    check_flag("rsp_err", 1'b0, rsp_err);
    check_flag("no early pulses", 1'b1, rdy_pulses == 0 && err_pulses == 0);
    test_done("reset", e0);
  endtask

  task automatic test_write(output logic [6:0] addr);
    uart_cmd_pkg::cmd_t c;
    int                 e0;
    int                 r0;
    e0 = err_cnt;
    r0 = rdy_pulses;
    c = rand_cmd(1'b1);
    do_cmd(c, 0, 8'h00);
    mem[c.addr] = c.data;
    addr = c.addr;
    check_flag("read_rdy after write", 1'b1, rdy_pulses == r0);
    check_flag("cmd_rdy", 1'b1, cmd_rdy);
    test_done("write", e0);
  endtask

  task automatic test_read_pairs(input int n, output logic [6:0] addr);
    uart_cmd_pkg::cmd_t c;
    int                 e0;
    int                 r0;
    int                 f0;
    int                 i;
    e0 = err_cnt;
    for (i = 0; i < n; i++)
    begin
      c = rand_cmd(1'b1);
      do_cmd(c, 0, 8'h00);
      mem[c.addr] = c.data;
      c.wr   = 1'b0;
      c.data = ~c.data;  // ignored by the remote device on reads
      r0 = rdy_pulses;
      f0 = err_pulses;
      do_cmd(c, 1, mem[c.addr]);
      check_flag("one read_rdy pulse", 1'b1, rdy_pulses == r0 + 1);
      check_flag("no rsp_err pulse", 1'b1, err_pulses == f0);
      check_byte("read_data", mem[c.addr], read_data);
      addr = c.addr;
    end
    test_done("write then read", e0);
  endtask

  task automatic test_bad_parity(input logic [6:0] addr);
    uart_cmd_pkg::cmd_t c;
    logic [7:0]         prev;
    int                 e0;
    int                 r0;
    int                 f0;
    e0 = err_cnt;
    prev = read_data;
    r0 = rdy_pulses;
    f0 = err_pulses;
    c = '{wr: 1'b0, addr: addr, data: 8'h00};
    do_cmd(c, 2, ~prev);  // a byte that read_data does not hold yet
    check_flag("one rsp_err pulse", 1'b1, err_pulses == f0 + 1);
    check_flag("no read_rdy pulse", 1'b1, rdy_pulses == r0);
    check_byte("read_data", prev, read_data);
    test_done("bad parity", e0);
  endtask

  task automatic test_timeout(input logic [6:0] addr);
    uart_cmd_pkg::cmd_t c;
    int                 e0;
    int                 r0;
    int                 f0;
    e0 = err_cnt;
    r0 = rdy_pulses;
    f0 = err_pulses;
    c = '{wr: 1'b0, addr: addr, data: 8'h00};
    do_cmd(c, 0, 8'h00);
    check_flag("one rsp_err pulse", 1'b1, err_pulses == f0 + 1);
    check_flag("no read_rdy pulse", 1'b1, rdy_pulses == r0);
    // stop bit ends CPB/2 + 1 cycles after its sample point
    if (err_cycle - (last_stop_cycle + CPB / 2 + 1) < TOB * CPB)
    begin
      $display("rsp_err came before the response timeout had run out");
      err_cnt++;
    end
    test_done("response timeout", e0);
  endtask

  task automatic test_busy_ignore();
    uart_cmd_pkg::cmd_t a;
    uart_cmd_pkg::cmd_t b;
    uart_cmd_pkg::cmd_t got;
    int                 e0;
    e0 = err_cnt;
    a = rand_cmd(1'b1);
    b = a;
    b.addr = ~a.addr;
    b.data = ~a.data;
    send_cmd(a);
    fork
      capture_cmd(got);
      begin
        repeat (4) @(posedge clk);
        cmd_in  <= b;
        cmd_vld <= 1'b1;
        repeat (8) @(posedge clk);
        cmd_vld <= 1'b0;
      end
    join
    mem[a.addr] = a.data;
    check_cmd("tx frames while busy", a, got);
    wait_idle();
    repeat (4 * CPB) @(negedge clk);
    check_flag("tx idle after command", 1'b1, tx);
    test_done("cmd_vld while busy", e0);
  endtask

  initial
  begin
    logic [6:0] addr;
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    rx      = 1'b1;
    for (int i = 0; i < 128; i++)
      mem[i] = 8'(i * 37) ^ 8'h5a;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_write(addr);
    test_read_pairs(4, addr);
    test_bad_parity(addr);
    test_timeout(addr);
    test_busy_ignore();
    $display("checks passed %0d, errors %0d", pass_cnt, err_cnt);
    if (err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: uart_cmd_master.f
+incdir+verification
logic/uart_cmd_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/cmd_sequencer.sv
logic/uart_cmd_master.sv
verification/tb_uart_cmd_master.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, result taken from the simulation log
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -f uart_cmd_master.f \
  --top-module tb_uart_cmd_master -o sim_uart_cmd_master \
  && ./obj_dir/sim_uart_cmd_master > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q '^>>> PASS$' sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }
